// File: hdl/sdram_cmd_pkg.sv
// sdram command package with opcodes, the 24-bit command word and the address views
`default_nettype none

package sdram_cmd_pkg;

    // logical opcodes, mapped to ras/cas/we pins by the phy
    typedef enum logic [2:0] {
        OP_PRECHARGE    = 3'b001,
        OP_ACTIVATE     = 3'b011,
        OP_WRITE        = 3'b010,
        OP_READ         = 3'b110,
        OP_LOAD_MODE    = 3'b100,
        OP_AUTO_REFRESH = 3'b101,
        OP_NOP          = 3'b111
    } sdram_op_e;

    // mode register layout on a15..a0
    typedef struct packed {
        logic [5:0] reserved;      // a15..a10, kept zero
        logic       wr_burst_mode; // 0 = burst writes
        logic [1:0] op_mode;       // 00 = standard operation
        logic [2:0] cas_latency;
        logic       burst_type;    // 0 = sequential
        logic [2:0] burst_len;     // 111 = full page
    } sdram_mr_t;

    // row / column layout on a15..a0
    typedef struct packed {
        logic [4:0] upper;
        logic       a10;           // precharge all when set
        logic [9:0] low;
    } sdram_addr_t;

    // same 16 address bits, decoded by opcode
    typedef union packed {
        sdram_mr_t   mr;           // load mode only
        sdram_addr_t rc;           // everything else
    } sdram_addr_u;

    typedef struct packed {
        logic [2:0]  reserved;     // always zero
        logic [1:0]  bank;
        sdram_addr_u addr;
        sdram_op_e   op;
    } sdram_cmd_t;

endpackage

`default_nettype wire

// File: hdl/sdram_req_pkg.sv
// user request package with the request word, the per-bank request and the bank count
`default_nettype none

package sdram_req_pkg;

    parameter int BANK_N = 4;

    // one user read or write
    typedef struct packed {
        logic        write;        // 1 = write, 0 = read
        logic [1:0]  bank;
        logic [15:0] row;
        logic [11:0] col;
    } sdram_req_t;

    // bank bits already used for routing
    typedef struct packed {
        logic        write;
        logic [15:0] row;
        logic [11:0] col;
    } sdram_bank_req_t;

endpackage

`default_nettype wire

// File: hdl/sdram_init_cmd_gen.sv
// sdram init command generator, waits out the power-up pause then streams the init sequence
`timescale 1ns/1ps
`default_nettype none

module sdram_init_cmd_gen #(
    parameter real CLK_PERIOD  = 7.0,      // ns
    parameter real INIT_PAUSE  = 250000.0, // ns
    parameter int  BURST_LEN   = 8,        // 1, 2, 4, 8, else full page
    parameter int  CAS_LATENCY = 2,        // 2 or 3
    parameter int  AUTO_RFS_N  = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic                      init_done,
    output sdram_cmd_pkg::sdram_cmd_t init_cmd,
    output logic                      init_valid,
    input  logic                      init_ready
);

    localparam int WAIT_P = int'($ceil(INIT_PAUSE / CLK_PERIOD));
    localparam int INIT_N = 6 + AUTO_RFS_N; // pre, mrs, 4 nop, refreshes

    localparam logic [2:0] BL_CODE = (BURST_LEN == 1) ? 3'b000 :
                                     (BURST_LEN == 2) ? 3'b001 :
                                     (BURST_LEN == 4) ? 3'b010 :
                                     (BURST_LEN == 8) ? 3'b011 : 3'b111;
    localparam logic [2:0] CL_CODE = (CAS_LATENCY == 3) ? 3'b011 : 3'b010;

    logic [$clog2(WAIT_P + 1)-1:0] pause_cnt;
    logic                          pause_done; // pause elapsed
    logic [$clog2(INIT_N)-1:0]     idx;        // word being offered
    logic                          xfer;
    logic                          last;

    assign xfer = init_valid & init_ready;
    assign last = idx == INIT_N - 1;

    // power-up pause, counts once and then holds
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pause_cnt  <= '0;
            pause_done <= 1'b0;
        end
        else if (!pause_done)
        begin
            pause_cnt  <= pause_cnt + 1'b1;
            pause_done <= pause_cnt == WAIT_P - 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idx        <= '0;
            init_valid <= 1'b0;
            init_done  <= 1'b0;
        end
        else
        begin
            if (xfer)
                idx <= idx + 1'b1; // wraps after the last word, unused then
            if (xfer && last)
            begin
                init_valid <= 1'b0;
                init_done  <= 1'b1; // one cycle after final transfer
            end
            else if (pause_done && !init_done)
                init_valid <= 1'b1;
        end
    end

    // word decode from the index, stable while idx holds
    always_comb
    begin
        init_cmd    = '0;
        init_cmd.op = sdram_cmd_pkg::OP_NOP; // idx 2..5
        if (idx == 0)
        begin
            init_cmd.op         = sdram_cmd_pkg::OP_PRECHARGE;
            init_cmd.addr.rc.a10 = 1'b1; // all banks
        end
        else if (idx == 1)
        begin
            init_cmd.op                   = sdram_cmd_pkg::OP_LOAD_MODE;
            init_cmd.addr.mr.cas_latency = CL_CODE;
            init_cmd.addr.mr.burst_len   = BL_CODE; // sequential, burst writes
        end
        else if (idx >= 6)
            init_cmd.op = sdram_cmd_pkg::OP_AUTO_REFRESH;
    end

    // payload and valid hold until the scheduler takes the word
    a_init_hold : assert property (@(posedge clk) disable iff (!rst_n)
        init_valid && !init_ready |=> init_valid && $stable(init_cmd));

endmodule

`default_nettype wire

// File: hdl/sdram_req_router.sv
// request router, hands user requests to the bank trackers and queues the bank order
`timescale 1ns/1ps
`default_nettype none

module sdram_req_router (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           init_done,
    input  sdram_req_pkg::sdram_req_t      req,
    input  logic                           req_valid,
    output logic                           req_ready,
    output sdram_req_pkg::sdram_bank_req_t bank_req [sdram_req_pkg::BANK_N],
    output logic [sdram_req_pkg::BANK_N-1:0] bank_req_valid,
    input  logic [sdram_req_pkg::BANK_N-1:0] bank_req_ready,
    output logic [1:0]                     order_bank,
    output logic                           order_valid,
    input  logic                           order_pop
);

    logic [1:0] fifo_mem [4]; // bank numbers in request order
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] fifo_cnt;     // 0..4
    logic       full;
    logic       push;

    assign full      = fifo_cnt == 3'd4;
    assign req_ready = init_done & bank_req_ready[req.bank] & ~full;
    assign push      = req_valid & req_ready;

    // same payload to every bank, strobe only the addressed one
    always_comb
    begin
        for (int b = 0; b < sdram_req_pkg::BANK_N; b++)
        begin
            bank_req[b].write = req.write;
            bank_req[b].row   = req.row;
            bank_req[b].col   = req.col;
            bank_req_valid[b] = push && (req.bank == b);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= req.bank;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (order_pop)
                rd_ptr <= rd_ptr + 1'b1;
            fifo_cnt <= fifo_cnt + push - order_pop; // push and pop together hold
        end
    end

    assign order_bank  = fifo_mem[rd_ptr];
    assign order_valid = fifo_cnt != 3'd0;

    // scheduler pops only queued entries, count agrees with the pointers
    a_order_fifo : assert property (@(posedge clk) disable iff (!rst_n)
        !(order_pop && !order_valid) && fifo_cnt[1:0] == 2'(wr_ptr - rd_ptr));

endmodule

`default_nettype wire

// File: hdl/sdram_bank_tracker.sv
// bank tracker, keeps one bank's open row and expands a request into its command words
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_tracker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [1:0]                     bank_id,
    input  sdram_req_pkg::sdram_bank_req_t bank_req,
    input  logic                           bank_req_valid,
    output logic                           bank_req_ready,
    output sdram_cmd_pkg::sdram_cmd_t      bank_cmd,
    output logic                           bank_cmd_valid,
    output logic                           bank_last,
    input  logic                           bank_cmd_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRE,  // close the wrong row
        ST_ACT,  // open the wanted row
        ST_ACC   // read or write
    } state_e;

    state_e                         state;
    sdram_req_pkg::sdram_bank_req_t cur;       // request in progress
    logic                           open_flag; // a row is open
    logic [15:0]                    open_row;
    logic                           accept;
    logic                           xfer;

    assign accept         = bank_req_valid & bank_req_ready;
    assign xfer           = bank_cmd_valid & bank_cmd_ready;
    assign bank_req_ready = state == ST_IDLE;
    assign bank_cmd_valid = state != ST_IDLE;
    assign bank_last      = state == ST_ACC; // access always ends a request

    always_ff @(posedge clk)
    begin
        if (accept)
            cur <= bank_req;
        if (xfer && state == ST_ACT)
            open_row <= cur.row;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            open_flag <= 1'b0; // all banks precharged by init
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (accept)
                    begin
                        if (!open_flag)
                            state <= ST_ACT;
                        else if (open_row == bank_req.row)
                            state <= ST_ACC; // row hit
                        else
                            state <= ST_PRE; // row miss
                    end
                ST_PRE:
                    if (xfer)
                    begin
                        state     <= ST_ACT;
                        open_flag <= 1'b0;
                    end
                ST_ACT:
                    if (xfer)
                    begin
                        state     <= ST_ACC;
                        open_flag <= 1'b1;
                    end
                default:
                    if (xfer)
                        state <= ST_IDLE;
            endcase
        end
    end

    // command word for the current step
    always_comb
    begin
        bank_cmd      = '0;
        bank_cmd.bank = bank_id;
        bank_cmd.op   = sdram_cmd_pkg::OP_NOP; // idle, valid is low
        case (state)
            ST_PRE:
                bank_cmd.op = sdram_cmd_pkg::OP_PRECHARGE; // a10 low, this bank only
            ST_ACT:
            begin
                bank_cmd.op      = sdram_cmd_pkg::OP_ACTIVATE;
                bank_cmd.addr.rc = cur.row;
            end
            ST_ACC:
            begin
                bank_cmd.op = cur.write ? sdram_cmd_pkg::OP_WRITE : sdram_cmd_pkg::OP_READ;
                bank_cmd.addr.rc.upper = {3'b000, cur.col[11:10]};
                bank_cmd.addr.rc.low   = cur.col[9:0]; // a10 low, no auto-precharge
            end
            default: ;
        endcase
    end

    // access only goes out against the row this request opened or hit
    a_access_open : assert property (@(posedge clk) disable iff (!rst_n)
        bank_cmd_valid && bank_last |-> open_flag && open_row == cur.row);

endmodule

`default_nettype wire

// File: hdl/sdram_cmd_sched.sv
// command scheduler, passes the init stream and then drains bank trackers in request order
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_sched (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init_done,
    input  sdram_cmd_pkg::sdram_cmd_t init_cmd,
    input  logic                      init_valid,
    output logic                      init_ready,
    input  sdram_cmd_pkg::sdram_cmd_t bank_cmd [sdram_req_pkg::BANK_N],
    input  logic [sdram_req_pkg::BANK_N-1:0] bank_cmd_valid,
    input  logic [sdram_req_pkg::BANK_N-1:0] bank_last,
    output logic [sdram_req_pkg::BANK_N-1:0] bank_cmd_ready,
    input  logic [1:0]                order_bank,
    input  logic                      order_valid,
    output logic                      order_pop,
    output sdram_cmd_pkg::sdram_cmd_t cmd,
    output logic                      cmd_valid,
    input  logic                      cmd_ready
);

    logic head_valid; // head bank has a word ready
    logic head_last;

    assign head_valid = order_valid & bank_cmd_valid[order_bank];
    assign head_last  = bank_last[order_bank];

    // init words first, the trackers are empty until init_done anyway
    assign init_ready = ~init_done & cmd_ready;

    always_comb
    begin
        if (!init_done)
        begin
            cmd       = init_cmd;
            cmd_valid = init_valid;
        end
        else
        begin
            cmd       = bank_cmd[order_bank];
            cmd_valid = head_valid;
        end
    end

    // ready back to the head bank only, others wait their turn
    always_comb
    begin
        for (int b = 0; b < sdram_req_pkg::BANK_N; b++)
            bank_cmd_ready[b] = init_done && order_valid && order_bank == b && cmd_ready;
    end

    // head retires with its last word
    assign order_pop = init_done & head_valid & cmd_ready & head_last;

    // the word on the port belongs to the queue head
    a_head_only : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && init_done |-> order_valid && cmd.bank == order_bank);

    // a request's words stay together until its last one
    a_no_interleave : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && cmd_ready && init_done && !head_last
        |=> cmd_valid && cmd.bank == $past(cmd.bank));

endmodule

`default_nettype wire

// File: hdl/sdram_cmd_core.sv
// sdram command front end top, init generator, request router, four bank trackers, scheduler
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_core #(
    parameter real CLK_PERIOD  = 7.0,
    parameter real INIT_PAUSE  = 250000.0,
    parameter int  BURST_LEN   = 8,
    parameter int  CAS_LATENCY = 2,
    parameter int  AUTO_RFS_N  = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  sdram_req_pkg::sdram_req_t req,
    input  logic                      req_valid,
    output logic                      req_ready,
    output sdram_cmd_pkg::sdram_cmd_t cmd,
    output logic                      cmd_valid,
    input  logic                      cmd_ready,
    output logic                      init_done
);

    sdram_cmd_pkg::sdram_cmd_t       init_cmd;
    logic                            init_valid;
    logic                            init_ready;
    sdram_req_pkg::sdram_bank_req_t  bank_req [sdram_req_pkg::BANK_N];
    logic [sdram_req_pkg::BANK_N-1:0] bank_req_valid;
    logic [sdram_req_pkg::BANK_N-1:0] bank_req_ready;
    sdram_cmd_pkg::sdram_cmd_t       bank_cmd [sdram_req_pkg::BANK_N];
    logic [sdram_req_pkg::BANK_N-1:0] bank_cmd_valid;
    logic [sdram_req_pkg::BANK_N-1:0] bank_cmd_ready;
    logic [sdram_req_pkg::BANK_N-1:0] bank_last;
    logic [1:0]                      order_bank;
    logic                            order_valid;
    logic                            order_pop;

    sdram_init_cmd_gen #(
        .CLK_PERIOD (CLK_PERIOD),
        .INIT_PAUSE (INIT_PAUSE),
        .BURST_LEN  (BURST_LEN),
        .CAS_LATENCY(CAS_LATENCY),
        .AUTO_RFS_N (AUTO_RFS_N)
    ) u_init (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_done (init_done),
        .init_cmd  (init_cmd),
        .init_valid(init_valid),
        .init_ready(init_ready)
    );

    sdram_req_router u_router (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_done     (init_done),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .bank_req      (bank_req),
        .bank_req_valid(bank_req_valid),
        .bank_req_ready(bank_req_ready),
        .order_bank    (order_bank),
        .order_valid   (order_valid),
        .order_pop     (order_pop)
    );

    // one tracker per bank, index doubles as bank select
    for (genvar i = 0; i < sdram_req_pkg::BANK_N; i++)
    begin : g_bank
        sdram_bank_tracker u_tracker (
            .clk           (clk),
            .rst_n         (rst_n),
            .bank_id       (2'(i)),
            .bank_req      (bank_req[i]),
            .bank_req_valid(bank_req_valid[i]),
            .bank_req_ready(bank_req_ready[i]),
            .bank_cmd      (bank_cmd[i]),
            .bank_cmd_valid(bank_cmd_valid[i]),
            .bank_last     (bank_last[i]),
            .bank_cmd_ready(bank_cmd_ready[i])
        );
    end

    sdram_cmd_sched u_sched (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_done     (init_done),
        .init_cmd      (init_cmd),
        .init_valid    (init_valid),
        .init_ready    (init_ready),
        .bank_cmd      (bank_cmd),
        .bank_cmd_valid(bank_cmd_valid),
        .bank_last     (bank_last),
        .bank_cmd_ready(bank_cmd_ready),
        .order_bank    (order_bank),
        .order_valid   (order_valid),
        .order_pop     (order_pop),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready)
    );

endmodule

`default_nettype wire

// File: bench/sdram_cmd_core_tb.sv
// testbench for the sdram command front end, vector driven with random back-pressure
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_core_tb;

    localparam real CLK_PERIOD = 100.0;    // ns
    localparam real INIT_PAUSE = 2000.0;   // ns
    localparam int  AUTO_RFS_N = 2;
    localparam int  INIT_WORDS = 6 + AUTO_RFS_N; // pre, mrs, 4 nop, refreshes
    localparam int  TEST_N     = 5;

    logic                      clk;
    logic                      rst_n;
    sdram_req_pkg::sdram_req_t req;
    logic                      req_valid;
    logic                      req_ready;
    sdram_cmd_pkg::sdram_cmd_t cmd;
    logic                      cmd_valid;
    logic                      cmd_ready;
    logic                      init_done;

    sdram_req_pkg::sdram_req_t req_q [$];  // requests in file order
    logic [23:0]               exp_word [$];
    int                        exp_test [$]; // owning test of each word
    string                     test_name [1:TEST_N];
    int                        test_err [1:TEST_N];
    bit                        test_done [1:TEST_N];

    logic [31:0] lfsr;
    int          exp_n = 0;
    int          exp_idx = 0;   // next expected word
    int          req_idx = 0;
    int          gap_cnt = 0;   // idle cycles before next request
    int          cycles = 0;
    int          limit = 0;
    int          vec_lines = 0;
    int          err_total = 0;
    int          extra_err = 0;
    int          n_pass = 0;
    bit          req_taken = 1'b0;
    bit          timed_out = 1'b0;
    bit          load_err = 1'b0;

    sdram_cmd_core #(
        .CLK_PERIOD (CLK_PERIOD),
        .INIT_PAUSE (INIT_PAUSE),
        .BURST_LEN  (4),
        .CAS_LATENCY(3),
        .AUTO_RFS_N (AUTO_RFS_N)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .init_done(init_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr); // one step per bit
            v    = {v[2:0], lfsr[0]};
        end
    endtask

    task automatic compare(input int t, input logic [23:0] exp, input logic [23:0] act);
        if (exp !== act)
        begin
            $display("FAIL %s: expected %h, actual %h", test_name[t], exp, act);
            test_err[t]++;
            err_total++;
        end
    endtask

    task automatic finish_test(input int t);
        test_done[t] = 1'b1;
        if (test_err[t] == 0)
            $display("test %0d %s: ok", t, test_name[t]);
        else
            $display("test %0d %s: %0d mismatches", t, test_name[t], test_err[t]);
    endtask

    // Q test write bank row col, E test count words, anything else is a comment
    task automatic read_vectors;
        int                        fd;
        int                        cnt;
        int                        t;
        int                        w;
        int                        b;
        int                        n;
        logic [15:0]               row;
        logic [11:0]               col;
        logic [23:0]               word;
        logic [7:0]                tag;
        logic [8*160-1:0]          rest;
        sdram_req_pkg::sdram_req_t r;
        fd = $fopen("bench/sdram_cmd_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("vector file bench/sdram_cmd_vectors.txt could not be opened");
            load_err = 1'b1;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1)
        begin
            if (tag == "Q")
            begin
                cnt     = $fscanf(fd, "%d %d %d %h %h", t, w, b, row, col);
                r.write = w[0];
                r.bank  = b[1:0];
                r.row   = row;
                r.col   = col;
                req_q.push_back(r);
                vec_lines++;
            end
            else if (tag == "E")
            begin
                cnt = $fscanf(fd, "%d %d", t, n);
                for (int k = 0; k < n; k++)
                begin
                    cnt = $fscanf(fd, "%h", word);
                    exp_word.push_back(word);
                    exp_test.push_back(t);
                end
                vec_lines++;
            end
            else
                cnt = $fgets(rest, fd); // skip rest of comment line
        end
        $fclose(fd);
        exp_n = exp_word.size();
        if (exp_n == 0 && !load_err)
        begin
            $display("vector file holds no expected command words");
            load_err = 1'b1;
        end
    endtask

    task automatic check_word;
        int t;
        if (exp_idx >= exp_n)
        begin
            $display("unexpected command word %h after the last expected one", cmd);
            extra_err++;
        end
        else
        begin
            t = exp_test[exp_idx];
            compare(t, exp_word[exp_idx], cmd);
            exp_idx++;
            if (exp_idx == exp_n || exp_test[exp_idx] != t)
                finish_test(t); // last word of this test
        end
    endtask

    // inputs change on the falling edge only
    always @(negedge clk)
    begin : drive
        logic [3:0] r;
        if (rst_n)
        begin
            rand_bits(2, r);
            cmd_ready = r[1:0] != 2'b00; // ready about 3 cycles in 4
            if (!req_valid || req_taken)
            begin
                req_valid = 1'b0;
                if (gap_cnt > 0)
                    gap_cnt--;
                else if (req_idx < req_q.size())
                begin
                    req       = req_q[req_idx];
                    req_valid = 1'b1; // held until the router takes it
                    req_idx++;
                    rand_bits(2, r);
                    gap_cnt = r;
                end
            end
        end
    end

    // sample on the rising edge, before the dut flops update
    always @(posedge clk)
    begin
        cycles++;
        if (rst_n)
        begin
            req_taken = req_valid & req_ready;
            if (!init_done)
                compare(2, 24'd0, req_ready); // no request accepted during init
            if (exp_idx < INIT_WORDS)
                compare(1, 24'd0, init_done); // done only after the last init word
            if (cmd_valid && cmd_ready)
                check_word();
        end
        if (limit > 0 && cycles >= limit)
            timed_out = 1'b1;
    end

    initial
    begin
        rst_n     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        cmd_ready = 1'b0;
        lfsr      = 32'h30af;
        test_name[1] = "init sequence";
        test_name[2] = "requests held before init";
        test_name[3] = "closed bank";
        test_name[4] = "row hit and row miss";
        test_name[5] = "ordering under back-pressure";
        for (int t = 1; t <= TEST_N; t++)
        begin
            test_err[t]  = 0;
            test_done[t] = 1'b0;
        end
        read_vectors();
        // reset, pause, init words at half rate, then 20 cycles per vector line
        limit = 10 + int'($ceil(INIT_PAUSE / CLK_PERIOD)) + 1 + 2 * INIT_WORDS
                + 20 * vec_lines;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1; // driver starts on the next falling edge
        wait (exp_idx == exp_n || timed_out);
        repeat (5) @(posedge clk); // catch stray words
        if (timed_out)
            $display("timeout after %0d cycles, only %0d of %0d command words came out",
                     cycles, exp_idx, exp_n);
        for (int t = 1; t <= TEST_N; t++)
        begin
            if (test_done[t] && test_err[t] == 0)
                n_pass++;
            else if (!test_done[t])
                $display("test %0d %s: did not finish", t, test_name[t]);
        end
        $display("tests: %0d passed, %0d failed, %0d mismatches, %0d extra words",
                 n_pass, TEST_N - n_pass, err_total, extra_err);
        if (n_pass == TEST_N && extra_err == 0 && !load_err && !timed_out)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/sdram_cmd_vectors.txt
# Q test write bank row col, row and col in hex
# E test count, then count expected 24-bit command words in hex, in output order
E 1 8 002001 000194 000007 000007 000007 000007 000005 000005
Q 2 0 0 0012 034
E 2 2 000093 0001a6
Q 3 1 1 0345 0c7
E 3 2 081a2b 08063a
Q 3 0 2 1f00 c05
E 3 2 10f803 10c02e
Q 4 1 0 0012 100
E 4 1 000802
Q 4 0 1 0346 3ff
E 4 3 080001 081a33 081ffe
Q 5 1 3 0100 010
E 5 2 180803 180082
Q 5 0 0 0012 020
E 5 1 000106
Q 5 1 2 1f01 400
E 5 3 100001 10f80b 104002
Q 5 0 1 0346 001
E 5 1 08000e
Q 5 0 3 0200 002
E 5 3 180001 181003 180016
Q 5 1 0 ffff fff
E 5 3 000001 07fffb 00dffa

// File: sdram_cmd_core.f
hdl/sdram_cmd_pkg.sv
hdl/sdram_req_pkg.sv
hdl/sdram_init_cmd_gen.sv
hdl/sdram_req_router.sv
hdl/sdram_bank_tracker.sv
hdl/sdram_cmd_sched.sv
hdl/sdram_cmd_core.sv
bench/sdram_cmd_core_tb.sv

// File: Bender.yml
package:
  name: sdram_cmd_core

sources:
  - files:
      - hdl/sdram_cmd_pkg.sv
      - hdl/sdram_req_pkg.sv
      - hdl/sdram_init_cmd_gen.sv
      - hdl/sdram_req_router.sv
      - hdl/sdram_bank_tracker.sv
      - hdl/sdram_cmd_sched.sv
      - hdl/sdram_cmd_core.sv
  - target: test
    files:
      - bench/sdram_cmd_core_tb.sv
